/* common/spi_mem_pkg.sv */
//----------------------------
// SPI memory shared definitions
// Widths, depth and the pin and command structs
//----------------------------

package spi_mem_pkg;

    //----------------------------
    // Sizes
    //----------------------------

    localparam int ADDR_W      = 7;    // Address bits in the command byte
    localparam int DATA_W      = 8;    // One SPI byte
    localparam int MEM_DEPTH   = 128;  // 2**ADDR_W words
    localparam int SYNC_STAGES = 2;    // Metastability flops per pin

    //----------------------------
    // Conditioned pin
    //----------------------------

    // Output of one pin_sync instance
    typedef struct packed {
        logic level;  // Synchronized pin value
        logic rise;   // One cycle on a 0 to 1 change of level
        logic fall;   // One cycle on a 1 to 0 change of level
    } pin_state_t;

    //----------------------------
    // Controller to datapath
    //----------------------------

    // All fields are registered in spi_frame_ctrl
    typedef struct packed {
        logic addr_we;   // Latch address from the command byte
        logic mem_we;    // Store the data byte
        logic sr_load;   // Parallel load of the read byte
        logic shift_en;  // Shift mosi in on rising sclk
        logic miso_oe;   // Enable the miso pad driver
    } frame_cmd_t;

    // Command byte layout, MSB first on the wire:
    //   [7:1] address
    //   [0]   read flag, 1 = read

endpackage : spi_mem_pkg

/* hw/pin_sync.sv */
//----------------------------
// Pin synchronizer
// Brings one SPI pin into clk and flags its edges
//----------------------------

`timescale 1ns/1ps

module pin_sync import spi_mem_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       pin,          // Raw SPI pin, asynchronous to clk
    input  logic       reset_level,  // Idle value of the pin
    output pin_state_t state
);

    logic [SYNC_STAGES-1:0] sync_q;   // Flop chain, index 0 sees the pin
    logic                   level_d;  // Level one cycle back

    //----------------------------
    // Synchronizer chain
    //----------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            // Preload idle level so no edge fires out of reset
            sync_q  <= {SYNC_STAGES{reset_level}};
            level_d <= reset_level;
        end else begin
            sync_q  <= {sync_q[SYNC_STAGES-2:0], pin};
            level_d <= sync_q[SYNC_STAGES-1];  // Edge detect flop
        end
    end

    //----------------------------
    // Edge pulses
    //----------------------------

    // Pulses line up with the cycle in which level changes
    always_comb begin
        state.level = sync_q[SYNC_STAGES-1];
        state.rise  = sync_q[SYNC_STAGES-1] & ~level_d;
        state.fall  = ~sync_q[SYNC_STAGES-1] & level_d;
    end

endmodule : pin_sync

/* spi_slave/spi_frame_ctrl.sv */
//----------------------------
// SPI frame controller
// Counts sclk edges, decodes the command byte, sequences datapath
//----------------------------

`timescale 1ns/1ps

module spi_frame_ctrl import spi_mem_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  pin_state_t sclk_st,
    input  pin_state_t cs_st,
    input  logic       rw_bit,   // Shift register LSB once the command byte is in
    output frame_cmd_t cmd
);

    typedef enum logic [2:0] {
        st_idle,     // Waiting for cs to fall
        st_cmd,      // Shifting in address and read flag
        st_latch,    // Address latch cycle, flag decoded here
        st_rd_wait,  // Memory read cycle
        st_rd_out,   // Data byte goes out on miso
        st_wr_data   // Data byte comes in on mosi
    } state_t;

    state_t     state;
    logic [3:0] bit_cnt;  // Rising sclk edges seen in this frame

    logic sclk_step;      // Counted rising edge
    logic last_cmd_bit;   // 8th rise of the frame
    logic last_data_bit;  // 16th rise of the frame

    assign sclk_step     = sclk_st.rise & cmd.shift_en;
    assign last_cmd_bit  = sclk_step && (bit_cnt == 4'd7);
    assign last_data_bit = sclk_step && (bit_cnt == 4'd15);

    //----------------------------
    // Frame FSM
    //----------------------------

    always_ff @(posedge clk) begin
        if (reset || cs_st.rise) begin
            // cs high ends or aborts the frame
            state   <= st_idle;
            bit_cnt <= 4'd0;
            cmd     <= '0;
        end else begin
            // One cycle pulses
            cmd.addr_we <= 1'b0;
            cmd.mem_we  <= 1'b0;
            cmd.sr_load <= 1'b0;

            if (sclk_step) begin
                bit_cnt <= bit_cnt + 4'd1;
            end

            case (state)
                st_idle: begin
                    if (cs_st.fall) begin
                        state        <= st_cmd;
                        bit_cnt      <= 4'd0;  // Fresh frame
                        cmd.shift_en <= 1'b1;
                    end
                end

                st_cmd: begin
                    if (last_cmd_bit) begin
                        state       <= st_latch;
                        cmd.addr_we <= 1'b1;  // Lands on the cycle after the 8th rise
                    end
                end

                st_latch: begin
                    // Command byte fully shifted, LSB is the read flag
                    if (rw_bit) begin
                        state <= st_rd_wait;
                    end else begin
                        state <= st_wr_data;
                    end
                end

                st_rd_wait: begin
                    // rd_data settles at the end of this cycle
                    state       <= st_rd_out;
                    cmd.sr_load <= 1'b1;
                    cmd.miso_oe <= 1'b1;
                end

                st_rd_out: begin
                    // Hold until cs rises
                    state <= st_rd_out;
                end

                st_wr_data: begin
                    if (last_data_bit) begin
                        // Full data byte in, commit it
                        state        <= st_idle;
                        cmd.mem_we   <= 1'b1;
                        cmd.shift_en <= 1'b0;
                    end
                end

                default: begin
                    state <= st_idle;
                    cmd   <= '0;
                end
            endcase
        end
    end

endmodule : spi_frame_ctrl

/* spi_slave/spi_shift_reg.sv */
//----------------------------
// SPI shift register
// Serial in from mosi, parallel load, falling edge miso flop
//----------------------------

`timescale 1ns/1ps

module spi_shift_reg import spi_mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  pin_state_t        sclk_st,
    input  pin_state_t        mosi_st,
    input  frame_cmd_t        cmd,
    input  logic [DATA_W-1:0] load_data,  // Read byte from memory
    output logic [DATA_W-1:0] sr_byte,    // Parallel view of the register
    output logic              miso
);

    logic [DATA_W-1:0] shift_q;
    logic              miso_q;

    //----------------------------
    // Shift register
    //----------------------------

    // Load wins over shift in the same cycle
    always_ff @(posedge clk) begin
        if (cmd.sr_load) begin
            shift_q <= load_data;
        end else if (cmd.shift_en && sclk_st.rise) begin
            shift_q <= {shift_q[DATA_W-2:0], mosi_st.level};  // MSB first on the wire
        end
    end

    assign sr_byte = shift_q;

    //----------------------------
    // miso output flop
    //----------------------------

    // Updates on falling sclk, so data is steady at the master's rising edge
    always_ff @(posedge clk) begin
        if (reset) begin
            miso_q <= 1'b0;
        end else if (sclk_st.fall) begin
            miso_q <= shift_q[DATA_W-1];
        end
    end

    assign miso = miso_q;

endmodule : spi_shift_reg

/* hw/mem_array.sv */
//----------------------------
// Memory array
// Address latch and 128 x 8 synchronous RAM
//----------------------------

`timescale 1ns/1ps

module mem_array import spi_mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  frame_cmd_t        cmd,
    input  logic [DATA_W-1:0] sr_byte,  // Command byte or write data
    output logic [DATA_W-1:0] rd_data
);

    logic [ADDR_W-1:0] addr_q;              // Latched frame address
    logic [DATA_W-1:0] mem [MEM_DEPTH];     // Storage, no reset

    //----------------------------
    // Address latch
    //----------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_q <= '0;
        end else if (cmd.addr_we) begin
            addr_q <= sr_byte[DATA_W-1 -: ADDR_W];  // Drop the read flag
        end
    end

    //----------------------------
    // RAM
    //----------------------------

    // Registered read of the latched address, every cycle
    always_ff @(posedge clk) begin
        if (cmd.mem_we) begin
            mem[addr_q] <= sr_byte;
        end
        rd_data <= mem[addr_q];  // Valid one cycle after the latch
    end

endmodule : mem_array

/* hw/spi_memory.sv */
//----------------------------
// SPI slave memory, top level
// Mode 0 SPI access to a 128 byte RAM
//----------------------------

`timescale 1ns/1ps

module spi_memory import spi_mem_pkg::*; (
    input  logic clk,      // System clock
    input  logic reset,
    input  logic sclk,     // SPI clock, half period >= 8 clk
    input  logic cs,       // Chip select, active low
    input  logic mosi,
    output logic miso,
    output logic miso_oe   // Pad driver enable
);

    pin_state_t        sclk_st;
    pin_state_t        cs_st;
    pin_state_t        mosi_st;
    frame_cmd_t        cmd;
    logic [DATA_W-1:0] sr_byte;
    logic [DATA_W-1:0] rd_data;

    //----------------------------
    // Pin conditioning
    //----------------------------

    pin_sync sclk_sync (.clk(clk), .reset(reset), .pin(sclk), .reset_level(1'b0), .state(sclk_st));
    pin_sync cs_sync   (.clk(clk), .reset(reset), .pin(cs),   .reset_level(1'b1), .state(cs_st));
    pin_sync mosi_sync (.clk(clk), .reset(reset), .pin(mosi), .reset_level(1'b0), .state(mosi_st));

    //----------------------------
    // Control and datapath
    //----------------------------

    spi_frame_ctrl frame_ctrl (
        .clk     (clk),
        .reset   (reset),
        .sclk_st (sclk_st),
        .cs_st   (cs_st),
        .rw_bit  (sr_byte[0]),  // Read flag after the command byte
        .cmd     (cmd)
    );

    spi_shift_reg shift_reg (
        .clk       (clk),
        .reset     (reset),
        .sclk_st   (sclk_st),
        .mosi_st   (mosi_st),
        .cmd       (cmd),
        .load_data (rd_data),
        .sr_byte   (sr_byte),
        .miso      (miso)
    );

    mem_array mem (
        .clk     (clk),
        .reset   (reset),
        .cmd     (cmd),
        .sr_byte (sr_byte),
        .rd_data (rd_data)
    );

    assign miso_oe = cmd.miso_oe;  // Tristate buffer lives outside

endmodule : spi_memory

/* dv/spi_memory_props.sv */
//----------------------------
// SPI memory assertions
// Controller commands checked against chip select
//----------------------------

`timescale 1ns/1ps

module spi_memory_props import spi_mem_pkg::*; (
    input logic       clk,
    input logic       reset,
    input pin_state_t cs_st,
    input frame_cmd_t cmd
);

    int fail_count = 0;  // Read by the testbench at the end

    // miso_oe drops on the edge after the cs rise pulse
    oe_needs_cs: assert property (@(posedge clk) disable iff (reset)
        cmd.miso_oe |-> (!cs_st.level || cs_st.rise))
    else begin
        fail_count++;
        $error("miso_oe high while cs is deasserted");
    end

    // Write and read load belong to different frame types
    we_not_with_load: assert property (@(posedge clk) disable iff (reset)
        !(cmd.mem_we && cmd.sr_load))
    else begin
        fail_count++;
        $error("mem_we and sr_load in the same cycle");
    end

    we_needs_cs: assert property (@(posedge clk) disable iff (reset)
        cmd.mem_we |-> !cs_st.level)
    else begin
        fail_count++;
        $error("memory write outside a frame");
    end

endmodule : spi_memory_props

bind spi_memory spi_memory_props props0 (
    .clk   (clk),
    .reset (reset),
    .cs_st (cs_st),
    .cmd   (cmd)
);

/* dv/spi_memory_tb.sv */
//----------------------------
// SPI memory testbench
// Bit-banged mode 0 master driven from a frame table
//----------------------------

`timescale 1ns/1ps

module spi_memory_tb import spi_mem_pkg::*; ();

    localparam int HALF_CYC   = 10;         // clk cycles per sclk half period
    localparam int OE_TIMEOUT = 50;         // Cycles allowed for miso_oe to drop
    localparam int NUM_FRAMES = 16;
    localparam int SEED       = 10709;
    localparam int RUN_LIMIT  = 1_000_000;  // ns, whole run

    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_ABORT = 2'd2;  // Write cut off mid data byte

    typedef struct packed {
        logic [1:0]        op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic              rand_data;  // Data byte from $urandom
        logic [DATA_W-1:0] expected;   // Read value, taken from the model
    } frame_row_t;

    logic clk = 1'b0;
    logic reset;
    logic sclk;
    logic cs;
    logic mosi;
    logic miso;
    logic miso_oe;

    frame_row_t        frames [NUM_FRAMES];
    logic [DATA_W-1:0] model  [MEM_DEPTH];  // Expected memory contents
    int                check_count;
    int                error_count;
    int                timeout_count;
    int                seed;

    spi_memory dut0 (
        .clk     (clk),
        .reset   (reset),
        .sclk    (sclk),
        .cs      (cs),
        .mosi    (mosi),
        .miso    (miso),
        .miso_oe (miso_oe)
    );

    always #10 clk = ~clk;  // 20 ns period

    //----------------------------
    // Helpers
    //----------------------------

    task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic set_row(input int idx, input logic [1:0] op, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data, input logic rand_data);
        frames[idx].op        = op;
        frames[idx].addr      = addr;
        frames[idx].data      = data;
        frames[idx].rand_data = rand_data;
        frames[idx].expected  = '0;
    endtask

    task automatic build_table();
        set_row(0,  OP_WRITE, 7'h15, 8'hA5, 1'b0);
        set_row(1,  OP_READ,  7'h15, 8'h00, 1'b0);  // Write then read back
        set_row(2,  OP_WRITE, 7'h00, 8'h00, 1'b1);  // Lowest address
        set_row(3,  OP_WRITE, 7'h7F, 8'h00, 1'b1);  // Highest address
        set_row(4,  OP_WRITE, 7'h3B, 8'h00, 1'b1);
        set_row(5,  OP_READ,  7'h00, 8'h00, 1'b0);
        set_row(6,  OP_READ,  7'h7F, 8'h00, 1'b0);
        set_row(7,  OP_READ,  7'h3B, 8'h00, 1'b0);
        set_row(8,  OP_WRITE, 7'h3B, 8'hC3, 1'b0);  // Overwrite
        set_row(9,  OP_READ,  7'h3B, 8'h00, 1'b0);
        set_row(10, OP_ABORT, 7'h15, 8'h00, 1'b0);
        set_row(11, OP_READ,  7'h15, 8'h00, 1'b0);  // Must still hold A5
        set_row(12, OP_WRITE, 7'h7F, 8'h00, 1'b0);  // All zero byte
        set_row(13, OP_ABORT, 7'h7F, 8'h00, 1'b0);
        set_row(14, OP_READ,  7'h7F, 8'h00, 1'b0);
        set_row(15, OP_READ,  7'h00, 8'h00, 1'b0);  // Untouched since row 2
    endtask

    // Walks the table in order, only full writes change the model
    task automatic fill_expected();
        logic [31:0] rnd;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            if (frames[i].rand_data) begin
                rnd = $urandom();
                frames[i].data = rnd[DATA_W-1:0];
            end
            case (frames[i].op)
                OP_WRITE: model[frames[i].addr] = frames[i].data;
                OP_READ:  frames[i].expected = model[frames[i].addr];
                default:  frames[i].data = ~model[frames[i].addr];  // Would show if stored
            endcase
        end
    endtask

    //----------------------------
    // SPI master
    //----------------------------

    // One mode 0 bit, sclk low on entry and on exit
    task automatic shift_bit(input logic out_bit, output logic in_bit, output logic oe_bit);
        @(posedge clk);
        mosi <= out_bit;
        repeat (HALF_CYC - 1) @(posedge clk);
        @(negedge clk);
        in_bit = miso;  // Just before rising sclk
        oe_bit = miso_oe;
        @(posedge clk);
        sclk <= 1'b1;
        repeat (HALF_CYC) @(posedge clk);
        sclk <= 1'b0;
    endtask

    task automatic wait_oe_low();
        int cycles;
        cycles = 0;
        while (miso_oe !== 1'b0 && cycles < OE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (miso_oe !== 1'b0) begin
            timeout_count++;
            $display("timeout at %0t ns: miso_oe still high %0d cycles after cs rose",
                     $time, OE_TIMEOUT);
        end
    endtask

    task automatic run_frame(input frame_row_t row);
        logic [DATA_W-1:0] cmd_byte;
        logic [DATA_W-1:0] rd_byte;
        logic              in_bit;
        logic              oe_bit;
        int                data_bits;
        cmd_byte  = {row.addr, row.op == OP_READ};  // Read flag in the LSB
        data_bits = (row.op == OP_ABORT) ? 4 : DATA_W;
        rd_byte   = '0;
        @(posedge clk);
        cs <= 1'b0;
        wait_cycles(HALF_CYC);
        for (int i = DATA_W - 1; i >= 0; i--) begin
            shift_bit(cmd_byte[i], in_bit, oe_bit);
            check_value("miso_oe", {7'b0, oe_bit}, 8'h00);  // Not driven yet
        end
        for (int i = 0; i < data_bits; i++) begin
            shift_bit((row.op == OP_READ) ? 1'b0 : row.data[DATA_W-1-i], in_bit, oe_bit);
            rd_byte[DATA_W-1-i] = in_bit;  // MSB first
            if (row.op == OP_READ) begin
                check_value("miso", {7'b0, in_bit}, {7'b0, row.expected[DATA_W-1-i]});
                check_value("miso_oe", {7'b0, oe_bit}, 8'h01);
            end else begin
                check_value("miso_oe", {7'b0, oe_bit}, 8'h00);
            end
        end
        wait_cycles(HALF_CYC);
        cs <= 1'b1;  // End of frame, or abort
        wait_oe_low();
        if (row.op == OP_READ) begin
            check_value("read byte", rd_byte, row.expected);
        end
    endtask

    //----------------------------
    // Main sequence
    //----------------------------

    initial begin
        reset         = 1'b1;
        sclk          = 1'b0;
        cs            = 1'b1;  // Idle high
        mosi          = 1'b0;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        seed          = SEED;
        void'($urandom(seed));
        build_table();
        fill_expected();

        wait_cycles(16);
        reset <= 1'b0;
        @(negedge clk);
        check_value("miso_oe", {7'b0, miso_oe}, 8'h00);  // Off out of reset
        wait_cycles(HALF_CYC);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(frames[f]);
            wait_cycles(2 * HALF_CYC);
            @(negedge clk);
            check_value("miso_oe", {7'b0, miso_oe}, 8'h00);  // cs high between frames
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
                 check_count, error_count, timeout_count, dut0.props0.fail_count);
        if (error_count == 0 && timeout_count == 0 && dut0.props0.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog for the whole run
    initial begin
        #(RUN_LIMIT);
        $display("timeout: run did not complete within %0d ns", RUN_LIMIT);
        $display("Simulation FAILED");
        $finish;
    end

endmodule : spi_memory_tb

/* verilog.f */
common/spi_mem_pkg.sv
hw/pin_sync.sv
spi_slave/spi_frame_ctrl.sv
spi_slave/spi_shift_reg.sv
hw/mem_array.sv
hw/spi_memory.sv
dv/spi_memory_props.sv
dv/spi_memory_tb.sv

/* Bender.yml */
package:
  name: spi_memory

sources:
  # RTL in compile order
  - common/spi_mem_pkg.sv
  - hw/pin_sync.sv
  - spi_slave/spi_frame_ctrl.sv
  - spi_slave/spi_shift_reg.sv
  - hw/mem_array.sv
  - hw/spi_memory.sv

  # Testbench and bound assertions
  - target: test
    files:
      - dv/spi_memory_props.sv
      - dv/spi_memory_tb.sv
